// File: files.f
serial_link_pkg.sv
serial_link_regs.sv
serial_link_network.sv
serial_link_data_link.sv
serial_link_phy.sv
serial_link.sv
serial_link_checker.sv
tb_serial_link.sv

// File: Makefile
TOP = tb_serial_link

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_serial_link.sv
// Link looped onto itself so both ends share clock, reset and configuration
`timescale 1ns/1ps

module tb_serial_link;
  import serial_link_pkg::*;

  // Cycles any single wait may take
  localparam int Timeout = 2000;

  logic                 clk;
  logic                 rst_n;
  logic [DataWidth-1:0] tx_data;
  logic                 tx_valid;
  logic                 tx_ready;
  logic [DataWidth-1:0] rx_data;
  logic                 rx_valid;
  logic                 rx_ready;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [3:0]           paddr;
  logic [31:0]          pwdata;
  logic                 pready;
  logic [31:0]          prdata;
  logic                 pslverr;
  flit_t                ddr;
  logic                 ddr_clk;
  integer               seed;
  logic [DataWidth-1:0] words [$];

  serial_link serial_link_inst (
    .clk_i         ( clk      ),
    .rst_n_i       ( rst_n    ),
    .tx_data_i     ( tx_data  ),
    .tx_valid_i    ( tx_valid ),
    .tx_ready_o    ( tx_ready ),
    .rx_data_o     ( rx_data  ),
    .rx_valid_o    ( rx_valid ),
    .rx_ready_i    ( rx_ready ),
    .psel_i        ( psel     ),
    .penable_i     ( penable  ),
    .pwrite_i      ( pwrite   ),
    .paddr_i       ( paddr    ),
    .pwdata_i      ( pwdata   ),
    .pready_o      ( pready   ),
    .prdata_o      ( prdata   ),
    .pslverr_o     ( pslverr  ),
    .ddr_o         ( ddr      ),
    .ddr_rcv_clk_o ( ddr_clk  ),
    .ddr_i         ( ddr      ),
    .ddr_rcv_clk_i ( ddr_clk  )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////
  // Failure and compare tasks
  ////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic cmp_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s expected 0x%0h actual 0x%0h", name, exp, act));
    end
  endtask

  task automatic cmp_credit(input string name, input credit_t exp, input credit_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic cmp_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
    end
  endtask

  // Handshake assertions stop the run as soon as one fails
  always @(negedge clk) begin
    if (serial_link_inst.checker_inst.fail_cnt != 0) begin
      abort_run("A handshake assertion failed");
    end
  end

  ////////////////////////////////////////
  // Bus and stream tasks
  ////////////////////////////////////////

  // Outputs are sampled on the falling edge, inputs change on the rising edge
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int cnt;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!pready && cnt < Timeout) begin
      @(negedge clk);
      cnt++;
    end
    if (!pready) begin
      abort_run("APB transfer never saw pready");
    end else begin
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
    end
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // On a timeout valid stays high so the word can be completed later
  task automatic send_word(input logic [31:0] data, output logic ok);
    int cnt;
    @(posedge clk);
    tx_valid <= 1'b1;
    tx_data  <= data;
    cnt = 0;
    @(negedge clk);
    while (!tx_ready && cnt < Timeout) begin
      @(negedge clk);
      cnt++;
    end
    ok = tx_ready;
    if (ok) begin
      @(posedge clk);
      tx_valid <= 1'b0;
    end
  endtask

  task automatic recv_word(output logic [31:0] data);
    int cnt;
    @(posedge clk);
    rx_ready <= 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!rx_valid && cnt < Timeout) begin
      @(negedge clk);
      cnt++;
    end
    if (!rx_valid) begin
      abort_run("No word arrived on the receive stream in time");
    end else begin
      data = rx_data;
      @(posedge clk);
      rx_ready <= 1'b0;
    end
  endtask

  task automatic wait_full_credits(input string name);
    logic [31:0] rd;
    logic        err;
    int          cnt;
    cnt = 0;
    apb_read(RegStatus, rd, err);
    while (credit_t'(rd) != credit_t'(NumCredits) && cnt < Timeout) begin
      apb_read(RegStatus, rd, err);
      cnt++;
    end
    cmp_credit(name, credit_t'(NumCredits), credit_t'(rd));
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reg_access;
    logic [31:0] rd;
    logic        err;
    apb_read(RegCtrl, rd, err);
    cmp_err("reset CTRL pslverr", 1'b0, err);
    cmp_word("reset CTRL", 32'd0, rd);
    apb_read(RegClkDiv, rd, err);
    cmp_word("reset CLK_DIV", 32'd4, rd);
    apb_read(RegStatus, rd, err);
    cmp_credit("reset STATUS", credit_t'(NumCredits), credit_t'(rd));
    apb_write(RegClkDiv, 32'd6, err);
    cmp_err("CLK_DIV write pslverr", 1'b0, err);
    apb_read(RegClkDiv, rd, err);
    cmp_word("CLK_DIV readback", 32'd6, rd);
  endtask

  task automatic illegal_access;
    logic [31:0] rd;
    logic        err;
    apb_write(RegClkDiv, 32'd3, err);
    cmp_err("odd CLK_DIV pslverr", 1'b1, err);
    apb_read(RegClkDiv, rd, err);
    cmp_word("CLK_DIV after odd write", 32'd6, rd);
    apb_write(RegClkDiv, 32'd1, err);
    cmp_err("small CLK_DIV pslverr", 1'b1, err);
    apb_read(RegClkDiv, rd, err);
    cmp_word("CLK_DIV after small write", 32'd6, rd);
    apb_write(RegStatus, 32'd0, err);
    cmp_err("STATUS write pslverr", 1'b1, err);
    apb_read(RegStatus, rd, err);
    cmp_credit("STATUS after write", credit_t'(NumCredits), credit_t'(rd));
    apb_read(4'hC, rd, err);
    cmp_err("unknown offset pslverr", 1'b1, err);
  endtask

  task automatic link_disabled;
    for (int cnt = 0; cnt < Timeout; cnt++) begin
      @(negedge clk);
      cmp_err("tx_ready with link disabled", 1'b0, tx_ready);
    end
  endtask

  task automatic loopback(input clk_div_t div);
    logic [31:0] rd;
    logic [31:0] word;
    logic        err;
    logic        ok;
    apb_write(RegClkDiv, 32'(div), err);
    cmp_err("loopback CLK_DIV pslverr", 1'b0, err);
    apb_write(RegCtrl, 32'd1, err);
    cmp_err("loopback CTRL pslverr", 1'b0, err);
    // Two rounds of a full credit window each
    for (int batch = 0; batch < 2; batch++) begin
      for (int i = 0; i < NumCredits; i++) begin
        word = $random(seed);
        words.push_back(word);
        send_word(word, ok);
        cmp_err("loopback send", 1'b1, ok);
      end
      for (int i = 0; i < NumCredits; i++) begin
        recv_word(rd);
        cmp_word("loopback data", words.pop_front(), rd);
      end
    end
    wait_full_credits("loopback STATUS");
  endtask

  task automatic back_pressure;
    logic [31:0] rd;
    logic [31:0] word;
    logic        err;
    logic        ok;
    for (int i = 0; i < NumCredits; i++) begin
      word = $random(seed);
      words.push_back(word);
      send_word(word, ok);
      cmp_err("send within credits", 1'b1, ok);
    end
    word = $random(seed);
    words.push_back(word);
    send_word(word, ok);
    cmp_err("send without credits", 1'b0, ok);
    apb_read(RegStatus, rd, err);
    cmp_credit("STATUS under back-pressure", credit_t'(0), credit_t'(rd));
    // Still blocked after the register access
    @(negedge clk);
    cmp_err("tx_ready without credits", 1'b0, tx_ready);
  endtask

  task automatic credit_return;
    logic [31:0] rd;
    logic        ok;
    recv_word(rd);
    cmp_word("first pending word", words[0], rd);
    void'(words.pop_front());
    // The held word is still on tx_data and completes once a credit is back
    send_word(words[words.size()-1], ok);
    cmp_err("held word send", 1'b1, ok);
    for (int i = 0; i < NumCredits; i++) begin
      recv_word(rd);
      cmp_word("credit return data", words.pop_front(), rd);
    end
    wait_full_credits("STATUS after credit return");
  endtask

  initial begin
    seed     = 32;
    rst_n    = 1'b0;
    tx_data  = '0;
    tx_valid = 1'b0;
    rx_ready = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    reg_access();
    illegal_access();
    link_disabled();
    loopback(8'd2);
    loopback(8'd6);
    back_pressure();
    credit_return();

    if (serial_link_inst.checker_inst.fail_cnt != 0) begin
      $display("Handshake assertions failed %0d times", serial_link_inst.checker_inst.fail_cnt);
      $display("Regression failed");
      $fatal(1, "Assertion failures during the run");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: serial_link_checker.sv
// Checks only handshake rules on the user streams and APB and does not look at payload contents
`timescale 1ns/1ps

module serial_link_checker (
  input logic                                 clk_i,
  input logic                                 rst_n_i,
  input logic [serial_link_pkg::DataWidth-1:0] tx_data_i,
  input logic                                 tx_valid_i,
  input logic                                 tx_ready_i,
  input logic [serial_link_pkg::DataWidth-1:0] rx_data_i,
  input logic                                 rx_valid_i,
  input logic                                 rx_ready_i,
  input logic                                 psel_i,
  input logic                                 penable_i,
  input logic                                 pready_i
);

  // Failures seen so far, read by the testbench
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////
  // Stream handshakes
  ////////////////////////////////////////

  tx_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_data_i))
    else begin
      fail_cnt++;
      $error("Transmit valid dropped or data changed before ready");
    end

  rx_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_valid_i && !rx_ready_i |=> rx_valid_i && $stable(rx_data_i))
    else begin
      fail_cnt++;
      $error("Receive valid dropped or data changed before ready");
    end

  ////////////////////////////////////////
  // APB
  ////////////////////////////////////////

  // Zero wait states put pready in the access cycle right after setup
  apb_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pready_i |-> psel_i && penable_i && $past(psel_i && !penable_i))
    else begin
      fail_cnt++;
      $error("pready high outside an access phase that follows setup");
    end

endmodule

bind serial_link serial_link_checker checker_inst (
  .clk_i      ( clk_i      ),
  .rst_n_i    ( rst_n_i    ),
  .tx_data_i  ( tx_data_i  ),
  .tx_valid_i ( tx_valid_i ),
  .tx_ready_i ( tx_ready_o ),
  .rx_data_i  ( rx_data_o  ),
  .rx_valid_i ( rx_valid_o ),
  .rx_ready_i ( rx_ready_i ),
  .psel_i     ( psel_i     ),
  .penable_i  ( penable_i  ),
  .pready_i   ( pready_o   )
);

// File: serial_link.sv
// One channel in a single clock domain where both link ends must share reset release
`timescale 1ns/1ps

module serial_link (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [serial_link_pkg::DataWidth-1:0] tx_data_i,
  input  logic                                 tx_valid_i,
  output logic                                 tx_ready_o,
  output logic [serial_link_pkg::DataWidth-1:0] rx_data_o,
  output logic                                 rx_valid_o,
  input  logic                                 rx_ready_i,
  input  logic                                 psel_i,
  input  logic                                 penable_i,
  input  logic                                 pwrite_i,
  input  logic [3:0]                           paddr_i,
  input  logic [31:0]                          pwdata_i,
  output logic                                 pready_o,
  output logic [31:0]                          prdata_o,
  output logic                                 pslverr_o,
  output serial_link_pkg::flit_t               ddr_o,
  output logic                                 ddr_rcv_clk_o,
  input  serial_link_pkg::flit_t               ddr_i,
  input  logic                                 ddr_rcv_clk_i
);
  import serial_link_pkg::*;

  cfg_t     cfg;
  credit_t  credits;
  payload_t pl_tx;
  logic     pl_tx_valid;
  logic     pl_tx_ready;
  payload_t pl_rx;
  logic     pl_rx_valid;
  flit_t    flit_tx;
  logic     flit_tx_valid;
  logic     flit_tx_ready;
  flit_t    flit_rx;
  logic     flit_rx_valid;

  ////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////

  serial_link_regs regs_inst (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .psel_i    ( psel_i    ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .paddr_i   ( paddr_i   ),
    .pwdata_i  ( pwdata_i  ),
    .pready_o  ( pready_o  ),
    .pslverr_o ( pslverr_o ),
    .prdata_o  ( prdata_o  ),
    .credits_i ( credits   ),
    .cfg_o     ( cfg       )
  );

  ////////////////////////////////////////
  // Link stages
  ////////////////////////////////////////

  serial_link_network network_inst (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .cfg_i         ( cfg         ),
    .tx_data_i     ( tx_data_i   ),
    .tx_valid_i    ( tx_valid_i  ),
    .tx_ready_o    ( tx_ready_o  ),
    .rx_data_o     ( rx_data_o   ),
    .rx_valid_o    ( rx_valid_o  ),
    .rx_ready_i    ( rx_ready_i  ),
    .pl_tx_o       ( pl_tx       ),
    .pl_tx_valid_o ( pl_tx_valid ),
    .pl_tx_ready_i ( pl_tx_ready ),
    .pl_rx_i       ( pl_rx       ),
    .pl_rx_valid_i ( pl_rx_valid ),
    .credits_o     ( credits     )
  );

  serial_link_data_link data_link_inst (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .pl_tx_i         ( pl_tx         ),
    .pl_tx_valid_i   ( pl_tx_valid   ),
    .pl_tx_ready_o   ( pl_tx_ready   ),
    .flit_tx_o       ( flit_tx       ),
    .flit_tx_valid_o ( flit_tx_valid ),
    .flit_tx_ready_i ( flit_tx_ready ),
    .flit_rx_i       ( flit_rx       ),
    .flit_rx_valid_i ( flit_rx_valid ),
    .pl_rx_o         ( pl_rx         ),
    .pl_rx_valid_o   ( pl_rx_valid   )
  );

  serial_link_phy phy_inst (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .cfg_i           ( cfg           ),
    .flit_tx_i       ( flit_tx       ),
    .flit_tx_valid_i ( flit_tx_valid ),
    .flit_tx_ready_o ( flit_tx_ready ),
    .ddr_o           ( ddr_o         ),
    .ddr_rcv_clk_o   ( ddr_rcv_clk_o ),
    .ddr_i           ( ddr_i         ),
    .ddr_rcv_clk_i   ( ddr_rcv_clk_i ),
    .flit_rx_o       ( flit_rx       ),
    .flit_rx_valid_o ( flit_rx_valid )
  );

endmodule

// File: serial_link_phy.sv
// Single data rate link that needs the incoming forwarded clock in the clk_i domain and clk_div even
`timescale 1ns/1ps

module serial_link_phy (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  serial_link_pkg::cfg_t  cfg_i,
  input  serial_link_pkg::flit_t flit_tx_i,
  input  logic                   flit_tx_valid_i,
  output logic                   flit_tx_ready_o,
  output serial_link_pkg::flit_t ddr_o,
  output logic                   ddr_rcv_clk_o,
  input  serial_link_pkg::flit_t ddr_i,
  input  logic                   ddr_rcv_clk_i,
  output serial_link_pkg::flit_t flit_rx_o,
  output logic                   flit_rx_valid_o
);
  import serial_link_pkg::*;

  clk_div_t div_cnt_q;
  logic     fwd_clk_q;
  logic     half_done;
  flit_t    ddr_q;
  logic     rcv_clk_q;
  logic     rcv_rise;
  flit_t    rx_flit_q;
  logic     rx_valid_q;

  ////////////////////////////////////////
  // Transmit serializer
  ////////////////////////////////////////

  // Greater-or-equal covers a divider lowered in mid period
  assign half_done = (div_cnt_q >= (cfg_i.clk_div - clk_div_t'(1)));

  // Flit done at the falling edge of the forwarded clock
  assign flit_tx_ready_o = flit_tx_valid_i && fwd_clk_q && half_done;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      div_cnt_q <= '0;
      fwd_clk_q <= 1'b0;
      ddr_q     <= '0;
    end else if (flit_tx_valid_i) begin
      // Data is updated one register stage after the falling edge
      ddr_q <= flit_tx_i;
      if (half_done) begin
        div_cnt_q <= '0;
        fwd_clk_q <= ~fwd_clk_q;
      end else begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  assign ddr_o         = ddr_q;
  assign ddr_rcv_clk_o = fwd_clk_q;

  ////////////////////////////////////////
  // Receive deserializer
  ////////////////////////////////////////

  assign rcv_rise = ddr_rcv_clk_i && !rcv_clk_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rcv_clk_q  <= 1'b0;
      rx_valid_q <= 1'b0;
    end else begin
      rcv_clk_q  <= ddr_rcv_clk_i;
      rx_valid_q <= rcv_rise;
    end
  end

  // Lanes are sampled half a period after they changed
  always_ff @(posedge clk_i) begin
    if (rcv_rise) begin
      rx_flit_q <= ddr_i;
    end
  end

  assign flit_rx_o       = rx_flit_q;
  assign flit_rx_valid_o = rx_valid_q;

endmodule

// File: serial_link_data_link.sv
// Both ends must leave reset together since flit framing is kept by counting from zero
`timescale 1ns/1ps

module serial_link_data_link (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  serial_link_pkg::payload_t pl_tx_i,
  input  logic                      pl_tx_valid_i,
  output logic                      pl_tx_ready_o,
  output serial_link_pkg::flit_t    flit_tx_o,
  output logic                      flit_tx_valid_o,
  input  logic                      flit_tx_ready_i,
  input  serial_link_pkg::flit_t    flit_rx_i,
  input  logic                      flit_rx_valid_i,
  output serial_link_pkg::payload_t pl_rx_o,
  output logic                      pl_rx_valid_o
);
  import serial_link_pkg::*;

  logic [PayloadBits-1:0] tx_sr_q;
  split_cnt_t             tx_cnt_q;
  logic                   tx_busy_q;
  logic                   tx_take;
  logic                   tx_shift;
  logic [PayloadBits-1:0] rx_sr_q;
  split_cnt_t             rx_cnt_q;
  logic                   rx_valid_q;

  ////////////////////////////////////////
  // Transmit split
  ////////////////////////////////////////

  assign pl_tx_ready_o   = !tx_busy_q;
  assign tx_take         = pl_tx_valid_i && pl_tx_ready_o;
  assign tx_shift        = flit_tx_valid_o && flit_tx_ready_i;
  assign flit_tx_valid_o = tx_busy_q;
  // Lowest flit first
  assign flit_tx_o       = tx_sr_q[NumLanes-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_busy_q <= 1'b0;
      tx_cnt_q  <= '0;
    end else if (tx_take) begin
      tx_busy_q <= 1'b1;
      tx_cnt_q  <= '0;
    end else if (tx_shift) begin
      if (tx_cnt_q == LastSplit) begin
        tx_busy_q <= 1'b0;
        tx_cnt_q  <= '0;
      end else begin
        tx_cnt_q <= tx_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_take) begin
      tx_sr_q <= pl_tx_i;
    end else if (tx_shift) begin
      tx_sr_q <= tx_sr_q >> NumLanes;
    end
  end

  ////////////////////////////////////////
  // Receive reassembly
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_cnt_q   <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= flit_rx_valid_i && (rx_cnt_q == LastSplit);
      if (flit_rx_valid_i) begin
        rx_cnt_q <= (rx_cnt_q == LastSplit) ? '0 : rx_cnt_q + 1'b1;
      end
    end
  end

  // New flits enter at the top so the first one ends up lowest
  always_ff @(posedge clk_i) begin
    if (flit_rx_valid_i) begin
      rx_sr_q <= {flit_rx_i, rx_sr_q[PayloadBits-1:NumLanes]};
    end
  end

  assign pl_rx_o       = payload_t'(rx_sr_q);
  assign pl_rx_valid_o = rx_valid_q;

endmodule

// File: serial_link_network.sv
// Word stream over credit flow control where the far side FIFO is NumCredits words deep
`timescale 1ns/1ps

module serial_link_network (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  serial_link_pkg::cfg_t                cfg_i,
  input  logic [serial_link_pkg::DataWidth-1:0] tx_data_i,
  input  logic                                 tx_valid_i,
  output logic                                 tx_ready_o,
  output logic [serial_link_pkg::DataWidth-1:0] rx_data_o,
  output logic                                 rx_valid_o,
  input  logic                                 rx_ready_i,
  output serial_link_pkg::payload_t            pl_tx_o,
  output logic                                 pl_tx_valid_o,
  input  logic                                 pl_tx_ready_i,
  input  serial_link_pkg::payload_t            pl_rx_i,
  input  logic                                 pl_rx_valid_i,
  output serial_link_pkg::credit_t             credits_o
);
  import serial_link_pkg::*;

  payload_t             pl_q;
  logic                 pl_valid_q;
  logic                 load_word;
  logic                 load_credit;
  credit_t              tx_cred_q;
  credit_t              owed_q;
  credit_t              cred_back;
  logic [DataWidth-1:0] fifo_mem [NumCredits];
  fifo_ptr_t            wr_ptr_q;
  fifo_ptr_t            rd_ptr_q;
  credit_t              fill_q;
  logic                 push;
  logic                 pop;

  ////////////////////////////////////////
  // Transmit
  ////////////////////////////////////////

  assign tx_ready_o  = cfg_i.link_en && (tx_cred_q != '0) && !pl_valid_q;
  assign load_word   = tx_valid_i && tx_ready_o;
  // Return owed credits when no word is going out
  assign load_credit = !load_word && cfg_i.link_en && !pl_valid_q && (owed_q != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pl_valid_q <= 1'b0;
    end else if (load_word || load_credit) begin
      pl_valid_q <= 1'b1;
    end else if (pl_tx_ready_i) begin
      pl_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_word || load_credit) begin
      pl_q.pad    <= '0;
      pl_q.credit <= owed_q;
      if (load_word) begin
        pl_q.tag  <= TagData;
        pl_q.data <= tx_data_i;
      end else begin
        pl_q.tag  <= TagCredit;
        pl_q.data <= '0;
      end
    end
  end

  assign pl_tx_o       = pl_q;
  assign pl_tx_valid_o = pl_valid_q;

  ////////////////////////////////////////
  // Credit counters
  ////////////////////////////////////////

  assign cred_back = pl_rx_valid_i ? pl_rx_i.credit : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_cred_q <= credit_t'(NumCredits);
      owed_q    <= '0;
    end else begin
      tx_cred_q <= tx_cred_q + cred_back - credit_t'(load_word);
      // The whole owed count leaves with the next payload
      if (load_word || load_credit) begin
        owed_q <= credit_t'(pop);
      end else begin
        owed_q <= owed_q + credit_t'(pop);
      end
    end
  end

  assign credits_o = tx_cred_q;

  ////////////////////////////////////////
  // Receive FIFO
  ////////////////////////////////////////

  // Never full on push since the sender holds a credit per slot
  assign push = pl_rx_valid_i && (pl_rx_i.tag == TagData);
  assign pop  = rx_valid_o && rx_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(push);
      rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(pop);
      fill_q   <= fill_q + credit_t'(push) - credit_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= pl_rx_i.data;
    end
  end

  assign rx_valid_o = (fill_q != '0);
  assign rx_data_o  = fifo_mem[rd_ptr_q];

endmodule

// File: serial_link_regs.sv
// Zero wait state APB slave without byte strobes and with only the offsets 0x0, 0x4 and 0x8
`timescale 1ns/1ps

module serial_link_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [3:0]               paddr_i,
  input  logic [31:0]              pwdata_i,
  output logic                     pready_o,
  output logic                     pslverr_o,
  output logic [31:0]              prdata_o,
  input  serial_link_pkg::credit_t credits_i,
  output serial_link_pkg::cfg_t    cfg_o
);
  import serial_link_pkg::*;

  cfg_t        cfg_q;
  logic        access;
  logic        err;
  logic        clk_div_ok;
  logic [31:0] rdata;

  // Access phase of an APB transfer
  assign access = psel_i & penable_i;

  // Divider must be even, at least 2 and fit in eight bits
  assign clk_div_ok = (pwdata_i[31:8] == '0) && (pwdata_i[7:0] >= 8'd2) && !pwdata_i[0];

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (paddr_i)
      RegCtrl: begin
        rdata = 32'(cfg_q.link_en);
      end
      RegClkDiv: begin
        rdata = 32'(cfg_q.clk_div);
        err   = pwrite_i && !clk_div_ok;
      end
      RegStatus: begin
        rdata = 32'(credits_i);
        // Read only
        err   = pwrite_i;
      end
      default: begin
        err = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q.link_en <= 1'b0;
      cfg_q.clk_div <= ClkDivReset;
    end else if (access && pwrite_i && !err) begin
      case (paddr_i)
        RegCtrl:   cfg_q.link_en <= pwdata_i[0];
        RegClkDiv: cfg_q.clk_div <= pwdata_i[7:0];
        default:   cfg_q         <= cfg_q;
      endcase
    end
  end

  assign pready_o  = access;
  assign pslverr_o = access & err;
  assign prdata_o  = (access && !pwrite_i) ? rdata : '0;
  assign cfg_o     = cfg_q;

endmodule

// File: serial_link_pkg.sv
// Assumes NumCredits is a power of two and PayloadBits is a multiple of NumLanes
package serial_link_pkg;

  ////////////////////////////////////////
  // Link dimensions
  ////////////////////////////////////////

  localparam int unsigned DataWidth  = 32;
  localparam int unsigned NumLanes   = 4;
  localparam int unsigned NumCredits = 4;

  // Credit count 0..NumCredits
  typedef logic [2:0] credit_t;

  // Receive FIFO pointer
  typedef logic [$clog2(NumCredits)-1:0] fifo_ptr_t;

  typedef enum logic [1:0] {
    TagData   = 2'b01,
    TagCredit = 2'b10
  } tag_e;

  ////////////////////////////////////////
  // Payload and flit
  ////////////////////////////////////////

  localparam int unsigned PayloadBits = 40;
  localparam int unsigned PadBits     = PayloadBits - $bits(tag_e) - $bits(credit_t) - DataWidth;

  // Data sits in the low bits and goes out first
  typedef struct packed {
    logic [PadBits-1:0]   pad;
    tag_e                 tag;
    credit_t              credit;
    logic [DataWidth-1:0] data;
  } payload_t;

  localparam int unsigned PayloadSplits = PayloadBits / NumLanes;

  typedef logic [$clog2(PayloadSplits)-1:0] split_cnt_t;
  localparam split_cnt_t LastSplit = split_cnt_t'(PayloadSplits - 1);

  typedef logic [NumLanes-1:0] flit_t;

  ////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////

  // Half period of the forwarded clock in clk_i cycles
  typedef logic [7:0] clk_div_t;

  typedef struct packed {
    logic     link_en;
    clk_div_t clk_div;
  } cfg_t;

  localparam clk_div_t ClkDivReset = 8'd4;

  localparam logic [3:0] RegCtrl   = 4'h0;
  localparam logic [3:0] RegClkDiv = 4'h4;
  localparam logic [3:0] RegStatus = 4'h8;

endpackage
